//--- Bender.yml
package:
  name: data_mem_path

sources:
  - source/cpu_pkg.sv
  - source/sram_pkg.sv
  - source/load_store_unit.sv
  - source/sram_control.sv
  - source/data_mem_path.sv
  - target: test
    files:
      - test/sram_model.sv
      - test/tb_data_mem_path.sv

//--- data_mem_path.f
source/cpu_pkg.sv
source/sram_pkg.sv
source/load_store_unit.sv
source/sram_control.sv
source/data_mem_path.sv
test/sram_model.sv
test/tb_data_mem_path.sv

//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_BYTES = 4;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // memory stage operation
    typedef enum logic [3:0] {
        RAM_NONE = 4'd0,
        RAM_LB   = 4'd1,
        RAM_LBU  = 4'd2,
        RAM_LH   = 4'd3,
        RAM_LHU  = 4'd4,
        RAM_LW   = 4'd5,
        RAM_SB   = 4'd6,
        RAM_SH   = 4'd7,
        RAM_SW   = 4'd8
    } ram_op_e;

    // MIPS cause codes
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } mem_exc_e;

    typedef struct packed {
        ram_op_e op;
        addr_t   addr;
        word_t   wdata;
    } mem_req_t;

endpackage

//--- source/data_mem_path.sv
`timescale 1ns/1ns

module data_mem_path (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  cpu_pkg::mem_req_t    req_i,
    output logic                 pause_o,
    output cpu_pkg::word_t       load_data_o,
    output cpu_pkg::mem_exc_e    exc_o,
    output sram_pkg::sram_pins_t sram_pins_o,
    inout  wire cpu_pkg::word_t  sram_data_io
);
    import cpu_pkg::*;
    import sram_pkg::*;

    sram_req_t sram_req;
    logic      success;
    word_t     rdata;

    // request decode and load formatting
    load_store_unit u_lsu (
        .req_i       (req_i),
        .success_i   (success),
        .rdata_i     (rdata),
        .sram_req_o  (sram_req),
        .pause_o     (pause_o),
        .load_data_o (load_data_o),
        .exc_o       (exc_o)
    );

    // external data SRAM sequencing
    sram_control u_sram_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .sram_req_i   (sram_req),
        .success_o    (success),
        .rdata_o      (rdata),
        .sram_pins_o  (sram_pins_o),
        .sram_data_io (sram_data_io)
    );

endmodule

//--- source/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  cpu_pkg::mem_req_t   req_i,
    input  logic                success_i,
    input  cpu_pkg::word_t      rdata_i,
    output sram_pkg::sram_req_t sram_req_o,
    output logic                pause_o,
    output cpu_pkg::word_t      load_data_o,
    output cpu_pkg::mem_exc_e   exc_o
);
    import cpu_pkg::*;
    import sram_pkg::*;

    logic                     is_load;
    logic                     is_store;
    logic                     is_half;
    logic                     is_word;
    logic                     misaligned;
    logic                     start;
    logic [SRAM_ADDR_LSB-1:0] offset;
    logic [WORD_BYTES-1:0]    be;
    word_t                    wdata_lanes;
    logic [7:0]               lane_byte;
    logic [15:0]              lane_half;

    assign offset = req_i.addr[SRAM_ADDR_LSB-1:0];

    // access class from the op code
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (req_i.op)
            RAM_LB, RAM_LBU: begin
                is_load = 1'b1;
            end
            RAM_LH, RAM_LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            RAM_LW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            RAM_SB: begin
                is_store = 1'b1;
            end
            RAM_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            RAM_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    assign misaligned = (is_half && offset[0]) || (is_word && (offset != '0));
    assign start      = (is_load || is_store) && !misaligned;

    always_comb begin
        if (!misaligned) begin
            exc_o = EXC_NONE;
        end else if (is_load) begin
            exc_o = EXC_ADEL;
        end else begin
            exc_o = EXC_ADES;
        end
    end

    // lane enables and store data placement
    always_comb begin
        if (is_word) begin
            be          = '1;
            wdata_lanes = req_i.wdata;
        end else if (is_half) begin
            be          = offset[1] ? 4'b1100 : 4'b0011;
            wdata_lanes = {(WORD_BYTES / 2){req_i.wdata[15:0]}};
        end else begin
            be          = 4'b0001 << offset;
            wdata_lanes = {WORD_BYTES{req_i.wdata[7:0]}};
        end
    end

    assign sram_req_o = '{
        start:     start,
        write:     is_store,
        word_addr: req_i.addr[SRAM_ADDR_LSB +: $bits(sram_addr_t)],
        be_n:      ~be,
        wdata:     wdata_lanes
    };

    // pick the addressed lane, then extend
    assign lane_byte = rdata_i[offset * 8 +: 8];
    assign lane_half = offset[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (req_i.op)
            RAM_LB:  load_data_o = {{24{lane_byte[7]}}, lane_byte};
            RAM_LBU: load_data_o = {24'd0, lane_byte};
            RAM_LH:  load_data_o = {{16{lane_half[15]}}, lane_half};
            RAM_LHU: load_data_o = {16'd0, lane_half};
            RAM_LW:  load_data_o = rdata_i;
            default: load_data_o = '0;
        endcase
    end

    // hold the pipeline until the controller reports completion
    assign pause_o = start && !success_i;

endmodule

//--- source/sram_control.sv
`timescale 1ns/1ns

module sram_control (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  sram_pkg::sram_req_t   sram_req_i,
    output logic                  success_o,
    output cpu_pkg::word_t        rdata_o,
    output sram_pkg::sram_pins_t  sram_pins_o,
    inout  wire cpu_pkg::word_t   sram_data_io
);
    import cpu_pkg::*;
    import sram_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE
    } state_e;

    state_e                state_q;
    logic [SRAM_CNT_W-1:0] cnt_q;
    logic                  last_cycle;
    logic                  launch;

    logic                  ce_n_q;
    logic                  oe_n_q;
    logic                  we_n_q;
    sram_be_n_t            be_n_q;
    logic                  drive_q;

    sram_addr_t            addr_q;
    word_t                 wdata_q;
    word_t                 rdata_q;

    assign launch     = (state_q == ST_IDLE) && sram_req_i.start;
    assign last_cycle = (state_q == ST_ACCESS) &&
                        (cnt_q == SRAM_CNT_W'(SRAM_ACCESS_CYCLES - 1));

    // strobes are registered so the pins never glitch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            ce_n_q  <= 1'b1;
            oe_n_q  <= 1'b1;
            we_n_q  <= 1'b1;
            be_n_q  <= '1;
            drive_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (launch) begin
                        state_q <= ST_ACCESS;
                        cnt_q   <= '0;
                        ce_n_q  <= 1'b0;
                        oe_n_q  <= sram_req_i.write;
                        we_n_q  <= !sram_req_i.write;
                        be_n_q  <= sram_req_i.be_n;
                        drive_q <= sram_req_i.write;
                    end
                end
                ST_ACCESS: begin
                    if (last_cycle) begin
                        state_q <= ST_DONE;
                        ce_n_q  <= 1'b1;
                        oe_n_q  <= 1'b1;
                        we_n_q  <= 1'b1;
                        be_n_q  <= '1;
                        drive_q <= 1'b0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            addr_q  <= sram_req_i.word_addr;
            wdata_q <= sram_req_i.wdata;
        end
        // sample read data before OE goes away
        if (last_cycle && !oe_n_q) begin
            rdata_q <= sram_data_io;
        end
    end

    assign sram_data_io = drive_q ? wdata_q : 'z;

    assign sram_pins_o = '{
        ce_n: ce_n_q,
        oe_n: oe_n_q,
        we_n: we_n_q,
        be_n: be_n_q,
        addr: addr_q
    };

    assign success_o = (state_q == ST_DONE);
    assign rdata_o   = rdata_q;

    no_oe_we_overlap: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(!oe_n_q && !we_n_q))
        else $error("OE and WE low together");

    drive_only_on_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        drive_q |-> !we_n_q)
        else $error("data bus driven outside a write");

    success_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        success_o |=> !success_o)
        else $error("success held longer than one cycle");

endmodule

//--- source/sram_pkg.sv
package sram_pkg;

    // byte address bit where the word address begins
    localparam int SRAM_ADDR_LSB = 2;

    // strobes stay low this many cycles
    localparam int SRAM_ACCESS_CYCLES = 2;
    localparam int SRAM_CNT_W = $clog2(SRAM_ACCESS_CYCLES);

    typedef logic [19:0] sram_addr_t;
    typedef logic [3:0]  sram_be_n_t;

    typedef struct packed {
        logic           start;
        logic           write;
        sram_addr_t     word_addr;
        sram_be_n_t     be_n;
        cpu_pkg::word_t wdata;
    } sram_req_t;

    typedef struct packed {
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
        sram_be_n_t be_n;
        sram_addr_t addr;
    } sram_pins_t;

endpackage

//--- test/sram_model.sv
`timescale 1ns/1ns

module sram_model #(
    parameter int DEPTH_WORDS = 1024
) (
    input  sram_pkg::sram_pins_t pins_i,
    inout  wire cpu_pkg::word_t  data_io
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    word_t mem [0:DEPTH_WORDS-1];
    logic  read_en;

    initial begin
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // write follows the bus while CE and WE are low
    always @(pins_i or data_io) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            // the bus floats as WE rises, so the last driven byte stays
            if (!pins_i.ce_n && !pins_i.we_n && !pins_i.be_n[b] &&
                !$isunknown(data_io[b*8 +: 8])) begin
                mem[pins_i.addr[IDX_W-1:0]][b*8 +: 8] = data_io[b*8 +: 8];
            end
        end
    end

    assign read_en = !pins_i.ce_n && !pins_i.oe_n && pins_i.we_n;

    // only enabled lanes drive the bus on a read
    for (genvar b = 0; b < WORD_BYTES; b++) begin : g_lane
        assign data_io[b*8 +: 8] = (read_en && !pins_i.be_n[b]) ?
                                   mem[pins_i.addr[IDX_W-1:0]][b*8 +: 8] : 8'bz;
    end

endmodule

//--- test/tb_data_mem_path.sv
`timescale 1ns/1ns

module tb_data_mem_path;
    import cpu_pkg::*;
    import sram_pkg::*;

    localparam int MEM_WORDS      = 1024;
    localparam int MEM_BYTES      = MEM_WORDS * WORD_BYTES;
    localparam int ACCESS_TIMEOUT = 20;

    logic       clk;
    logic       rst_n;
    mem_req_t   req;
    logic       pause;
    word_t      load_data;
    mem_exc_e   exc;
    sram_pins_t pins;
    wire word_t sram_data;

    // bytes the SRAM should hold, little endian
    logic [7:0] ref_mem [0:MEM_BYTES-1];
    integer     seed;

    data_mem_path i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .pause_o      (pause),
        .load_data_o  (load_data),
        .exc_o        (exc),
        .sram_pins_o  (pins),
        .sram_data_io (sram_data)
    );

    sram_model #(.DEPTH_WORDS(MEM_WORDS)) u_sram (
        .pins_i  (pins),
        .data_io (sram_data)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s (got 0x%08h, expected 0x%08h)",
                     $time, msg, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopping on timeout");
    endtask

    function automatic word_t expected_load(input ram_op_e op, input addr_t addr);
        int          idx;
        logic [7:0]  b;
        logic [15:0] h;
        idx = int'(addr % MEM_BYTES);
        b   = ref_mem[idx];
        h   = {ref_mem[(idx + 1) % MEM_BYTES], ref_mem[idx]};
        case (op)
            RAM_LB:  return {{24{b[7]}}, b};
            RAM_LBU: return {24'd0, b};
            RAM_LH:  return {{16{h[15]}}, h};
            RAM_LHU: return {16'd0, h};
            default: return {ref_mem[idx + 3], ref_mem[idx + 2], h};
        endcase
    endfunction

    function automatic void apply_store(input ram_op_e op, input addr_t addr,
                                        input word_t wdata);
        int idx;
        int n;
        idx = int'(addr % MEM_BYTES);
        n   = (op == RAM_SW) ? 4 : ((op == RAM_SH) ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            ref_mem[idx + i] = wdata[i*8 +: 8];
        end
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        req <= '0;
    endtask

    // one aligned access, returns once pause drops
    task automatic run_access(input ram_op_e op, input addr_t addr, input word_t wdata,
                              output word_t data);
        mem_req_t r;
        int       stalls;
        logic     is_write;
        r.op     = op;
        r.addr   = addr;
        r.wdata  = wdata;
        stalls   = 0;
        is_write = (op == RAM_SB) || (op == RAM_SH) || (op == RAM_SW);
        @(posedge clk);
        req <= r;
        @(negedge clk);
        while (pause) begin
            stalls++;
            if (stalls > ACCESS_TIMEOUT) begin
                abort_run($sformatf("%s at 0x%08h never completed", op.name(), addr));
            end
            // strobes are up from the second stall cycle
            if (stalls == 2) begin
                check_value(pins.ce_n, 1'b0, $sformatf("%s chip enable", op.name()));
                check_value(pins.we_n, !is_write, $sformatf("%s write enable", op.name()));
                check_value(pins.oe_n, is_write, $sformatf("%s output enable", op.name()));
                check_value(pins.addr, addr[21:2], $sformatf("%s word address", op.name()));
            end
            @(negedge clk);
        end
        data = load_data;
        // idle cycle plus the strobe cycles
        check_value(stalls, SRAM_ACCESS_CYCLES + 1, $sformatf("%s stall length", op.name()));
        check_value(exc, EXC_NONE, $sformatf("%s raised an exception", op.name()));
        check_value(pins.ce_n, 1'b1, "chip enable still low at completion");
    endtask

    task automatic do_store(input ram_op_e op, input addr_t addr, input word_t wdata);
        word_t unused;
        run_access(op, addr, wdata, unused);
        apply_store(op, addr, wdata);
    endtask

    task automatic do_load(input ram_op_e op, input addr_t addr);
        word_t data;
        run_access(op, addr, '0, data);
        check_value(data, expected_load(op, addr), $sformatf("%s at 0x%08h", op.name(), addr));
    endtask

    task automatic misaligned_access(input ram_op_e op, input addr_t addr,
                                     input mem_exc_e exp_exc);
        mem_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = 32'h5555_AAAA;
        @(posedge clk);
        req <= r;
        // watch a full access length for stray strobes
        for (int n = 0; n <= SRAM_ACCESS_CYCLES + 1; n++) begin
            @(negedge clk);
            check_value(exc, exp_exc, $sformatf("%s at 0x%08h exception", op.name(), addr));
            check_value(pause, 1'b0, $sformatf("%s at 0x%08h stalled", op.name(), addr));
            check_value(pins.ce_n, 1'b1, "chip enable on a misaligned access");
            check_value(pins.oe_n, 1'b1, "output enable on a misaligned access");
            check_value(pins.we_n, 1'b1, "write enable on a misaligned access");
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_value(pause, 1'b0, "pause after reset");
        check_value(pins.ce_n, 1'b1, "ce_n after reset");
        check_value(pins.oe_n, 1'b1, "oe_n after reset");
        check_value(pins.we_n, 1'b1, "we_n after reset");
        check_value(exc, EXC_NONE, "exception after reset");
    endtask

    task automatic test_word_timing();
        do_store(RAM_SW, 32'h40, 32'hDEAD_BEEF);
        do_load(RAM_LW, 32'h40);
        drive_idle();
    endtask

    task automatic test_subword_stores();
        do_store(RAM_SW, 32'h80, 32'h1122_3344);
        for (int off = 0; off < 4; off++) begin
            // upper bits are junk, only the low byte lands
            do_store(RAM_SB, 32'h80 + off, 32'hFFFF_FFA0 + off);
            do_load(RAM_LW, 32'h80);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_store(RAM_SH, 32'h80 + off, 32'hBEEF_5A00 + off);
            do_load(RAM_LW, 32'h80);
        end
        drive_idle();
    endtask

    task automatic test_subword_loads();
        do_store(RAM_SW, 32'h100, 32'h80F1_7F02);
        do_store(RAM_SW, 32'h104, 32'h7F01_80FF);
        for (int base = 32'h100; base <= 32'h104; base += 4) begin
            for (int off = 0; off < 4; off++) begin
                do_load(RAM_LB, base + off);
                do_load(RAM_LBU, base + off);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_load(RAM_LH, base + off);
                do_load(RAM_LHU, base + off);
            end
        end
        drive_idle();
    endtask

    task automatic test_address_errors();
        do_store(RAM_SW, 32'h200, 32'hCAFE_F00D);
        misaligned_access(RAM_LH, 32'h201, EXC_ADEL);
        misaligned_access(RAM_LHU, 32'h203, EXC_ADEL);
        misaligned_access(RAM_LW, 32'h201, EXC_ADEL);
        misaligned_access(RAM_LW, 32'h202, EXC_ADEL);
        misaligned_access(RAM_SH, 32'h201, EXC_ADES);
        misaligned_access(RAM_SH, 32'h203, EXC_ADES);
        misaligned_access(RAM_SW, 32'h202, EXC_ADES);
        misaligned_access(RAM_SW, 32'h203, EXC_ADES);
        do_load(RAM_LW, 32'h200);
        drive_idle();
    endtask

    task automatic test_random_traffic();
        addr_t addr;
        word_t data;
        for (int i = 0; i < 20; i++) begin
            addr = $random(seed) & (MEM_BYTES - WORD_BYTES);
            data = $random(seed);
            do_store(RAM_SW, addr, data);
            do_load(RAM_LW, addr);
        end
        drive_idle();
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = '0;
        seed  = 87;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_word_timing();
        test_subword_stores();
        test_subword_loads();
        test_address_errors();
        test_random_traffic();

        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule
